//--- Bender.yml
package:
  name: sd_init

sources:
  - files:
      - src/sd_init_pkg.sv
      - src/sd_pacing_timer.sv
      - src/sd_response_decoder.sv
      - src/sd_init_sequencer.sv
      - src/sd_init_top.sv
  - target: test
    files:
      - testbench/sd_card_model.sv
      - testbench/sd_init_tb.sv

//--- sources.f
src/sd_init_pkg.sv
src/sd_pacing_timer.sv
src/sd_response_decoder.sv
src/sd_init_sequencer.sv
src/sd_init_top.sv
testbench/sd_card_model.sv
testbench/sd_init_tb.sv

//--- src/sd_init_pkg.sv
package sd_init_pkg;

    // field widths
    localparam int CMD_IDX_W = 6;
    localparam int ARG_W     = 32;
    localparam int CMD_W     = CMD_IDX_W + ARG_W;  // index on top, argument below
    localparam int RESP_W    = 127;
    localparam int CID_W     = 127;
    localparam int RCA_W     = 16;

    // short response layout inside the 127-bit response word
    localparam int RESP_IDX_HI = RESP_W - 1;
    localparam int RESP_IDX_LO = RESP_W - CMD_IDX_W;
    localparam int RESP_PAY_HI = RESP_IDX_LO - 1;
    localparam int RESP_PAY_LO = RESP_W - CMD_W;

    // command indices
    localparam logic [CMD_IDX_W-1:0] CMD0   = 6'd0;   // GO_IDLE_STATE
    localparam logic [CMD_IDX_W-1:0] CMD2   = 6'd2;   // ALL_SEND_CID
    localparam logic [CMD_IDX_W-1:0] CMD3   = 6'd3;   // SEND_RELATIVE_ADDR
    localparam logic [CMD_IDX_W-1:0] CMD55  = 6'd55;  // APP_CMD
    localparam logic [CMD_IDX_W-1:0] ACMD41 = 6'd41;  // SD_SEND_OP_COND

    // host OCR, 3.2-3.4 V window
    localparam logic [ARG_W-1:0] HOST_OCR = 32'h0030_0000;

    // status and OCR checks
    localparam logic [ARG_W-1:0] R1_ERR_MASK   = 32'h0FFF_FE20;  // bits 27:9 and 5
    localparam logic [RCA_W-1:0] R6_ERR_MASK   = 16'hFE00;       // bits 15:9
    localparam int               OCR_BUSY_BIT  = 31;
    localparam logic [ARG_W-1:0] OCR_VOLT_MASK = 32'h0030_0000;

    // pacing limits
    localparam int TIMER_W      = 6;
    localparam int GAP_CYCLES   = 8;
    localparam int RESP_TIMEOUT = 5;

    // sequencer states
    localparam int ST_W = 4;
    localparam logic [ST_W-1:0] ST_CLK_ADJ  = 4'd0;
    localparam logic [ST_W-1:0] ST_SEND     = 4'd1;
    localparam logic [ST_W-1:0] ST_SENT     = 4'd2;
    localparam logic [ST_W-1:0] ST_RECV     = 4'd3;
    localparam logic [ST_W-1:0] ST_CAPTURE  = 4'd4;
    localparam logic [ST_W-1:0] ST_DECIDE   = 4'd5;
    localparam logic [ST_W-1:0] ST_GAP      = 4'd6;
    localparam logic [ST_W-1:0] ST_ERROR    = 4'd7;
    localparam logic [ST_W-1:0] ST_INACTIVE = 4'd8;

    // the 32-bit short response payload read three ways
    // r6[1] is the new RCA, r6[0] the short card status
    typedef union packed {
        logic [ARG_W-1:0]            card_status;  // R1
        logic [ARG_W-1:0]            ocr;          // R3
        logic [1:0][RCA_W-1:0]       r6;           // R6
    } resp_payload_u;

endpackage

//--- src/sd_init_sequencer.sv
`timescale 1ns/1ps

module sd_init_sequencer
    import sd_init_pkg::*;
(
    input  logic             ex_clk,
    input  logic             reset,
    input  logic             sd_cd_pin,
    input  logic             clk_div_cnt_gen_ok,
    input  logic             clk_div_cnt_gen_err,
    input  logic             sd_sending,
    input  logic             sd_send_finished,
    input  logic             sd_receive_finished,
    input  logic             crc_loaded,
    input  logic             crc_response_err,
    input  logic             gap_done,
    input  logic             resp_timeout,
    input  logic             r1_ok,
    input  logic             ocr_busy,
    input  logic             ocr_volt_ok,
    input  logic             r6_ok,
    output logic             clk_div_cnt_gen_start,
    output logic             send_en,
    output logic [CMD_W-1:0] send_cmd_content,
    output logic             receive_en,
    output logic             r2_response,
    output logic             r3_response,
    output logic             gap_run,
    output logic             wait_resp,
    output logic             resp_capture,
    output logic             cid_capture,
    output logic             rca_capture,
    output logic             init_done,
    output logic             init_failed,
    output logic             card_unusable
);

    logic [ST_W-1:0]      state, state_nxt;
    logic [CMD_IDX_W-1:0] step, step_nxt;  // index of the command in progress
    logic                 resp_end;
    logic                 set_done;
    logic                 set_unusable;
    logic [ARG_W-1:0]     cmd_arg;

    // R3 has no CRC, so its receive ends on the finish strobe
    assign resp_end = (step == ACMD41) ? sd_receive_finished : crc_loaded;

    always_comb begin
        state_nxt    = state;
        step_nxt     = step;
        set_done     = 1'b0;
        set_unusable = 1'b0;

        case (state)
            ST_CLK_ADJ: begin
                if (clk_div_cnt_gen_ok && sd_cd_pin) begin
                    state_nxt = ST_SEND;
                    step_nxt  = CMD0;
                end else if (clk_div_cnt_gen_err) begin
                    state_nxt = ST_ERROR;
                end
            end
            ST_SEND:
                if (sd_sending) state_nxt = ST_SENT;
            ST_SENT: begin
                if (sd_send_finished) begin
                    if (step == CMD0) begin
                        state_nxt = ST_GAP;  // no response to CMD0
                        step_nxt  = CMD55;
                    end else begin
                        state_nxt = ST_RECV;
                    end
                end
            end
            ST_RECV: begin
                if (resp_end) state_nxt = ST_CAPTURE;
                else if (resp_timeout) state_nxt = ST_ERROR;
            end
            ST_CAPTURE: state_nxt = ST_DECIDE;
            ST_DECIDE: begin
                case (step)
                    CMD55: begin
                        state_nxt = r1_ok ? ST_GAP : ST_ERROR;
                        step_nxt  = ACMD41;
                    end
                    ACMD41: begin
                        if (ocr_busy) begin
                            state_nxt = ST_GAP;  // card still powering up, retry
                            step_nxt  = CMD55;
                        end else if (!ocr_volt_ok) begin
                            state_nxt    = ST_INACTIVE;
                            set_unusable = 1'b1;
                        end else begin
                            state_nxt = ST_GAP;
                            step_nxt  = CMD2;
                        end
                    end
                    CMD2: begin
                        state_nxt = ST_GAP;
                        step_nxt  = CMD3;
                    end
                    CMD3: begin
                        state_nxt = r6_ok ? ST_INACTIVE : ST_ERROR;
                        set_done  = r6_ok;
                    end
                    default: state_nxt = ST_ERROR;
                endcase
            end
            ST_GAP:
                if (gap_done) state_nxt = ST_SEND;
            ST_ERROR: state_nxt = ST_INACTIVE;
            default: state_nxt = ST_INACTIVE;  // inactive holds
        endcase

        // CRC error aborts anything still running
        if (crc_response_err && state != ST_ERROR && state != ST_INACTIVE) begin
            state_nxt    = ST_ERROR;
            set_done     = 1'b0;
            set_unusable = 1'b0;
        end
    end

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            state         <= ST_CLK_ADJ;
            step          <= CMD0;
            init_done     <= 1'b0;
            init_failed   <= 1'b0;
            card_unusable <= 1'b0;
        end else begin
            state <= state_nxt;
            step  <= step_nxt;
            if (set_done) init_done <= 1'b1;
            if (set_unusable) card_unusable <= 1'b1;
            if (state_nxt == ST_ERROR) init_failed <= 1'b1;
        end
    end

    // only ACMD41 carries an argument, the rest send zeros
    assign cmd_arg = (step == ACMD41) ? HOST_OCR : '0;

    assign clk_div_cnt_gen_start = (state == ST_CLK_ADJ);
    assign send_en          = (state == ST_SEND) && !sd_sending;
    assign send_cmd_content = send_en ? {step, cmd_arg} : '0;
    assign receive_en       = (state == ST_SENT) && sd_send_finished && (step != CMD0);
    assign r2_response      = (state == ST_RECV) && (step == CMD2);
    assign r3_response      = (state == ST_RECV) && (step == ACMD41);
    assign gap_run          = (state == ST_GAP);
    assign wait_resp        = (state == ST_RECV);
    assign resp_capture     = (state == ST_CAPTURE);
    assign cid_capture      = (state == ST_CAPTURE) && (step == CMD2);
    assign rca_capture      = (state == ST_DECIDE) && (step == CMD3) && r6_ok;

endmodule

//--- src/sd_init_top.sv
`timescale 1ns/1ps

module sd_init_top
    import sd_init_pkg::*;
(
    input  logic              ex_clk,
    input  logic              reset,
    input  logic              sd_cd_pin,
    input  logic              clk_div_cnt_gen_ok,
    input  logic              clk_div_cnt_gen_err,
    input  logic              sd_sending,
    input  logic              sd_send_finished,
    input  logic              sd_receive_started,
    input  logic              sd_receive_finished,
    input  logic              crc_loaded,
    input  logic              crc_response_err,
    input  logic [RESP_W-1:0] response,
    output logic              clk_div_cnt_gen_start,
    output logic              send_en,
    output logic [CMD_W-1:0]  send_cmd_content,
    output logic              receive_en,
    output logic              r2_response,
    output logic              r3_response,
    output logic [CID_W-1:0]  cid,
    output logic [RCA_W-1:0]  rca,
    output logic              init_done,
    output logic              init_failed,
    output logic              card_unusable
);

    logic gap_run, wait_resp, gap_done, resp_timeout;
    logic resp_capture, cid_capture, rca_capture;
    logic r1_ok, ocr_busy, ocr_volt_ok, r6_ok;

    sd_init_sequencer u_seq (
        .ex_clk, .reset, .sd_cd_pin, .clk_div_cnt_gen_ok, .clk_div_cnt_gen_err,
        .sd_sending, .sd_send_finished, .sd_receive_finished, .crc_loaded,
        .crc_response_err, .gap_done, .resp_timeout,
        .r1_ok, .ocr_busy, .ocr_volt_ok, .r6_ok,
        .clk_div_cnt_gen_start, .send_en, .send_cmd_content, .receive_en,
        .r2_response, .r3_response, .gap_run, .wait_resp,
        .resp_capture, .cid_capture, .rca_capture,
        .init_done, .init_failed, .card_unusable
    );

    sd_pacing_timer u_timer (
        .ex_clk, .reset, .gap_run, .wait_resp, .sd_receive_started,
        .gap_done, .resp_timeout
    );

    sd_response_decoder u_dec (
        .ex_clk, .reset, .response, .resp_capture, .cid_capture, .rca_capture,
        .r1_ok, .ocr_busy, .ocr_volt_ok, .r6_ok, .cid, .rca
    );

endmodule

//--- src/sd_pacing_timer.sv
`timescale 1ns/1ps

module sd_pacing_timer
    import sd_init_pkg::*;
(
    input  logic ex_clk,
    input  logic reset,
    input  logic gap_run,
    input  logic wait_resp,
    input  logic sd_receive_started,
    output logic gap_done,
    output logic resp_timeout
);

    logic [TIMER_W-1:0] gap_cnt;
    logic [TIMER_W-1:0] to_cnt;

    // gap between commands, last gap cycle flags done
    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            gap_cnt <= '0;
        end else if (!gap_run) begin
            gap_cnt <= '0;
        end else begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    assign gap_done = gap_run && (gap_cnt == TIMER_W'(GAP_CYCLES - 1));

    // response timeout, any start bit from the card restarts the window
    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            to_cnt <= '0;
        end else if (!wait_resp || sd_receive_started) begin
            to_cnt <= '0;
        end else if (to_cnt != TIMER_W'(RESP_TIMEOUT)) begin
            to_cnt <= to_cnt + 1'b1;  // saturates at the limit
        end
    end

    assign resp_timeout = wait_resp && !sd_receive_started
                          && (to_cnt == TIMER_W'(RESP_TIMEOUT));

endmodule

//--- src/sd_response_decoder.sv
`timescale 1ns/1ps

module sd_response_decoder
    import sd_init_pkg::*;
(
    input  logic              ex_clk,
    input  logic              reset,
    input  logic [RESP_W-1:0] response,
    input  logic              resp_capture,
    input  logic              cid_capture,
    input  logic              rca_capture,
    output logic              r1_ok,
    output logic              ocr_busy,
    output logic              ocr_volt_ok,
    output logic              r6_ok,
    output logic [CID_W-1:0]  cid,
    output logic [RCA_W-1:0]  rca
);

    logic [CMD_IDX_W-1:0] resp_idx;
    resp_payload_u        resp_in;   // live payload from the receiver
    resp_payload_u        resp_q;    // payload held for the rca load

    assign resp_idx = response[RESP_IDX_HI:RESP_IDX_LO];
    assign resp_in  = response[RESP_PAY_HI:RESP_PAY_LO];

    always_ff @(posedge ex_clk) begin
        if (resp_capture) begin
            resp_q <= resp_in;
        end
    end

    // decode flags, valid in the cycle after the capture
    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            r1_ok       <= 1'b0;
            ocr_busy    <= 1'b0;
            ocr_volt_ok <= 1'b0;
            r6_ok       <= 1'b0;
        end else if (resp_capture) begin
            r1_ok       <= (resp_idx == CMD55)
                           && ((resp_in.card_status & R1_ERR_MASK) == '0);
            ocr_busy    <= !resp_in.ocr[OCR_BUSY_BIT];  // set bit means powered up
            ocr_volt_ok <= (resp_in.ocr & OCR_VOLT_MASK) != '0;
            r6_ok       <= (resp_in.r6[0] & R6_ERR_MASK) == '0;
        end
    end

    // whole R2 word is the CID
    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            cid <= '0;
        end else if (cid_capture) begin
            cid <= response;
        end
    end

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            rca <= '0;
        end else if (rca_capture) begin
            rca <= resp_q.r6[1];  // new RCA half of the R6 payload
        end
    end

endmodule

//--- testbench/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model
    import sd_init_pkg::*;
(
    input  logic              ex_clk,
    input  logic              send_en,
    input  logic [CMD_W-1:0]  send_cmd_content,
    input  logic              bad_r1,        // R1 error bit in the CMD55 reply
    input  logic              bad_idx,       // CMD55 reply with the wrong index
    input  logic              bad_r6,        // R6 error bit in the CMD3 reply
    input  logic              mute_cmd2,     // no reply at all to CMD2
    input  logic              crc_err_cmd2,  // CRC error while receiving CMD2
    input  logic [3:0]        busy_cnt,
    input  logic [1:0]        volt,
    input  logic [CID_W-1:0]  cid_val,
    input  logic [RCA_W-1:0]  rca_val,
    output logic              sd_sending,
    output logic              sd_send_finished,
    output logic              sd_receive_started,
    output logic              sd_receive_finished,
    output logic              crc_loaded,
    output logic              crc_response_err,
    output logic [RESP_W-1:0] response
);

    int            busy_left;
    resp_payload_u pay;

    task automatic tick();
        @(posedge ex_clk);
        #1;
    endtask

    // short reply sits in the top 38 bits
    function automatic logic [RESP_W-1:0] short_resp(input logic [CMD_IDX_W-1:0] idx,
                                                     input resp_payload_u p);
        return {idx, p, {(RESP_W - CMD_W){1'b0}}};
    endfunction

    task automatic build_reply(input logic [CMD_IDX_W-1:0] idx);
        pay = '0;
        case (idx)
            CMD55: begin
                pay.card_status = bad_r1 ? 32'h0080_0100 : 32'h0000_0100;  // bit 23 is a CRC error
                response = short_resp(bad_idx ? CMD3 : CMD55, pay);
            end
            ACMD41: begin
                pay.ocr[OCR_BUSY_BIT] = (busy_left == 0);  // powered up once retries run out
                pay.ocr[21:20]        = volt;
                if (busy_left > 0) busy_left--;
                response = short_resp(6'h3F, pay);
            end
            CMD2: response = cid_val;
            default: begin
                pay.r6[1] = rca_val;
                pay.r6[0] = bad_r6 ? 16'h8100 : 16'h0100;
                response  = short_resp(CMD3, pay);
            end
        endcase
    endtask

    // one command, from the send strobes through the reply
    task automatic serve(input logic [CMD_IDX_W-1:0] idx);
        #1;
        repeat ($urandom_range(2, 0)) tick();
        sd_sending = 1'b1;
        tick();
        sd_sending       = 1'b0;
        sd_send_finished = 1'b1;
        tick();
        sd_send_finished = 1'b0;
        if (idx == CMD0) begin
            busy_left = int'(busy_cnt);
        end else if (idx == CMD2 && crc_err_cmd2) begin
            crc_response_err = 1'b1;
            tick();
            crc_response_err = 1'b0;
        end else if (!(idx == CMD2 && mute_cmd2)) begin
            repeat ($urandom_range(2, 0)) tick();
            sd_receive_started = 1'b1;
            tick();
            sd_receive_started = 1'b0;
            repeat ($urandom_range(2, 0)) tick();
            build_reply(idx);
            if (idx == ACMD41) sd_receive_finished = 1'b1;  // R3 has no CRC
            else crc_loaded = 1'b1;
            tick();
            sd_receive_finished = 1'b0;
            crc_loaded          = 1'b0;
        end
    endtask

    initial begin
        sd_sending          = 1'b0;
        sd_send_finished    = 1'b0;
        sd_receive_started  = 1'b0;
        sd_receive_finished = 1'b0;
        crc_loaded          = 1'b0;
        crc_response_err    = 1'b0;
        response            = '0;
        busy_left           = 0;
        forever begin
            @(posedge ex_clk);
            if (send_en) serve(send_cmd_content[CMD_W-1:ARG_W]);
        end
    end

endmodule

//--- testbench/sd_init_tb.sv
`timescale 1ns/1ps

module sd_init_tb
    import sd_init_pkg::*;
();

    // fault codes for the scenario rows
    localparam logic [2:0] F_NONE = 3'd0;
    localparam logic [2:0] F_R1   = 3'd1;
    localparam logic [2:0] F_IDX  = 3'd2;
    localparam logic [2:0] F_R6   = 3'd3;
    localparam logic [2:0] F_MUTE = 3'd4;
    localparam logic [2:0] F_CRC  = 3'd5;
    localparam logic [2:0] F_CLK  = 3'd6;
    localparam logic [2:0] F_NOCD = 3'd7;

    typedef struct packed {
        logic [2:0] fault;
        logic [3:0] busy;   // busy ACMD41 replies before power-up
        logic [1:0] volt;   // OCR bits 21:20
        logic [2:0] flags;  // done, failed, unusable
    } row_t;

    localparam int N_ROWS   = 11;
    localparam int MAX_BUSY = 2;
    localparam int LIMIT    = N_ROWS * (MAX_BUSY + 6) * 40;

    localparam row_t ROWS [N_ROWS] = '{
        '{F_NONE, 4'd0, 2'b11, 3'b100},
        '{F_NONE, 4'd2, 2'b11, 3'b100},
        '{F_NONE, 4'd1, 2'b10, 3'b100},
        '{F_NONE, 4'd0, 2'b00, 3'b001},  // no voltage window match
        '{F_R1,   4'd0, 2'b11, 3'b010},
        '{F_IDX,  4'd0, 2'b11, 3'b010},
        '{F_R6,   4'd0, 2'b11, 3'b010},
        '{F_MUTE, 4'd0, 2'b11, 3'b010},
        '{F_CRC,  4'd1, 2'b11, 3'b010},
        '{F_CLK,  4'd0, 2'b11, 3'b010},
        '{F_NOCD, 4'd0, 2'b01, 3'b100}
    };

    logic ex_clk, reset, sd_cd_pin, clk_div_cnt_gen_ok, clk_div_cnt_gen_err;
    logic sd_sending, sd_send_finished, sd_receive_started, sd_receive_finished;
    logic crc_loaded, crc_response_err;
    logic [RESP_W-1:0] response;
    logic clk_div_cnt_gen_start, send_en, receive_en, r2_response, r3_response;
    logic [CMD_W-1:0] send_cmd_content;
    logic [CID_W-1:0] cid, cid_val;
    logic [RCA_W-1:0] rca, rca_val;
    logic init_done, init_failed, card_unusable;
    row_t cur;
    int   row;
    int   cycles;
    logic send_en_q;
    logic [CMD_IDX_W-1:0] cur_idx;  // index of the last command the card saw
    logic [CMD_W-1:0] sent [$];
    logic [CMD_W-1:0] exp_q [$];

    sd_init_top UUT (.*);

    sd_card_model card (
        .ex_clk, .send_en, .send_cmd_content,
        .bad_r1(cur.fault == F_R1), .bad_idx(cur.fault == F_IDX),
        .bad_r6(cur.fault == F_R6), .mute_cmd2(cur.fault == F_MUTE),
        .crc_err_cmd2(cur.fault == F_CRC), .busy_cnt(cur.busy), .volt(cur.volt),
        .cid_val, .rca_val, .sd_sending, .sd_send_finished, .sd_receive_started,
        .sd_receive_finished, .crc_loaded, .crc_response_err, .response
    );

    initial ex_clk = 1'b0;
    always #5 ex_clk = ~ex_clk;

    task automatic tick();
        @(posedge ex_clk);
        #1;
    endtask

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_flags(input logic done, input logic failed, input logic unusable,
                               input logic [2:0] exp);
        if ({done, failed, unusable} !== exp)
            stop_run($sformatf("ERR @%0t: row %0d flags %b, expected %b",
                               $time, row, {done, failed, unusable}, exp));
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("ERR @%0t: row %0d %s is %b, expected %b",
                               $time, row, what, got, exp));
    endtask

    task automatic check_cid(input logic [CID_W-1:0] got, input logic [CID_W-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("ERR @%0t: row %0d cid %h, expected %h", $time, row, got, exp));
    endtask

    task automatic check_rca(input logic [RCA_W-1:0] got, input logic [RCA_W-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("ERR @%0t: row %0d rca %h, expected %h", $time, row, got, exp));
    endtask

    task automatic check_cmd(input int n, input logic [CMD_W-1:0] got,
                             input logic [CMD_W-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("ERR @%0t: row %0d command %0d is %h, expected %h",
                               $time, row, n, got, exp));
    endtask

    // command order the card should see for the current row
    task automatic list_expected_cmds();
        exp_q.delete();
        if (cur.fault == F_CLK) return;
        exp_q.push_back({CMD0, 32'h0});
        if (cur.fault == F_R1 || cur.fault == F_IDX) begin
            exp_q.push_back({CMD55, 32'h0});
            return;
        end
        repeat (int'(cur.busy) + 1) begin
            exp_q.push_back({CMD55, 32'h0});
            exp_q.push_back({ACMD41, 32'h0030_0000});  // 3.2-3.4 V window
        end
        if (cur.volt == 2'b00) return;
        exp_q.push_back({CMD2, 32'h0});
        if (cur.fault == F_MUTE || cur.fault == F_CRC) return;
        exp_q.push_back({CMD3, 32'h0});
    endtask

    // command monitor, strobe checks and run limit
    always @(posedge ex_clk) begin
        cycles++;
        if (reset) begin
            sent.delete();
        end else begin
            if (send_en && !send_en_q) begin
                sent.push_back(send_cmd_content);
                cur_idx = send_cmd_content[CMD_W-1:ARG_W];
            end
            // receive starts with the send finish of any command but CMD0
            check_level("receive_en", receive_en, sd_send_finished && (cur_idx != CMD0));
            if (sd_receive_started || crc_loaded || sd_receive_finished) begin
                check_level("r2_response", r2_response, cur_idx == CMD2);
                check_level("r3_response", r3_response, cur_idx == ACMD41);
            end
        end
        send_en_q = send_en;
        if (cycles >= LIMIT) stop_run("simulation timed out waiting for a result");
    end

    initial begin
        logic [127:0] raw;
        logic         reached_cmd3;
        void'($urandom(32'h8278_d2e4));
        reset               = 1'b1;
        sd_cd_pin           = 1'b0;
        clk_div_cnt_gen_ok  = 1'b0;
        clk_div_cnt_gen_err = 1'b0;
        cur                 = ROWS[0];
        cid_val             = '0;
        rca_val             = '0;
        cycles              = 0;
        send_en_q           = 1'b0;
        cur_idx             = CMD0;
        for (row = 0; row < N_ROWS; row++) begin
            cur     = ROWS[row];
            raw     = {$urandom, $urandom, $urandom, $urandom};
            cid_val = raw[CID_W-1:0];
            rca_val = RCA_W'($urandom);
            reset               = 1'b1;
            sd_cd_pin           = 1'b0;
            clk_div_cnt_gen_ok  = 1'b0;
            clk_div_cnt_gen_err = 1'b0;
            repeat (5) tick();
            reset = 1'b0;
            repeat (2) tick();
            check_level("clk_div_cnt_gen_start", clk_div_cnt_gen_start, 1'b1);
            sd_cd_pin           = (cur.fault != F_NOCD);
            clk_div_cnt_gen_ok  = (cur.fault != F_CLK);
            clk_div_cnt_gen_err = (cur.fault == F_CLK);
            if (cur.fault == F_NOCD) begin
                repeat (10) begin
                    tick();
                    if (send_en) stop_run("send_en rose while the card-detect pin was low");
                    check_level("clk_div_cnt_gen_start", clk_div_cnt_gen_start, 1'b1);
                end
                sd_cd_pin = 1'b1;
            end
            while (!(init_done || init_failed || card_unusable)) tick();
            repeat (3) tick();  // let any late flag settle
            check_flags(init_done, init_failed, card_unusable, cur.flags);
            check_level("clk_div_cnt_gen_start", clk_div_cnt_gen_start, 1'b0);
            list_expected_cmds();
            if (sent.size() != exp_q.size())
                stop_run($sformatf("ERR @%0t: row %0d sent %0d commands, expected %0d",
                                   $time, row, sent.size(), exp_q.size()));
            foreach (exp_q[k]) check_cmd(k, sent[k], exp_q[k]);
            reached_cmd3 = (exp_q.size() > 0) && (exp_q[$][CMD_W-1:ARG_W] == CMD3);
            check_cid(cid, reached_cmd3 ? cid_val : '0);
            check_rca(rca, (reached_cmd3 && cur.fault != F_R6) ? rca_val : '0);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
